// File: include/l2_params.svh
`ifndef L2_PARAMS_SVH
`define L2_PARAMS_SVH

`define L2_ADDR_W    32
`define L2_LINE_W    128
`define L2_WORD_W    64
`define L2_OFF_W     4   // Byte offset bits within a line
`define L2_LG_LINES  4
`define L2_TAG_W     (`L2_ADDR_W - `L2_LG_LINES - `L2_OFF_W)

// Queue depth per client, equal to the credits a client holds after reset
`define L2_CREDITS   2

`define L2_MEM_LAT   4

`endif

// File: hw/l2_pkg.sv
`include "l2_params.svh"

package l2_pkg;

   typedef logic [`L2_ADDR_W-1:0]   paddr_t;
   typedef logic [`L2_LINE_W-1:0]   line_t;
   typedef logic [`L2_WORD_W-1:0]   word_t;
   typedef logic [`L2_LG_LINES-1:0] l2_idx_t;
   typedef logic [`L2_TAG_W-1:0]    l2_tag_t;
   typedef logic [63:0]             count_t;

   // Encoding doubles as the arbiter's rotation order
   typedef enum logic [1:0] {
      CLIENT_L1I = 2'd0,
      CLIENT_L1D = 2'd1,
      CLIENT_MMU = 2'd2
   } client_t;

   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } l2_op_t;

   typedef enum logic [2:0] {
      FLUSH_IDLE       = 3'd0,
      WAIT_FOR_L1D_L1I = 3'd1,
      GOT_L1D          = 3'd2,
      GOT_L1I          = 3'd3,
      FLUSH_L2         = 3'd4
   } flush_state_t;

   typedef enum logic [2:0] {
      IDLE       = 3'd0,
      LOOKUP     = 3'd1,
      WRITEBACK  = 3'd2,
      REFILL     = 3'd3,
      RESPOND    = 3'd4,
      FLUSH_WALK = 3'd5
   } l2_state_t;

endpackage

// File: hw/l2_ifs.sv
`timescale 1ns/100ps

// Head of one client queue as seen by the arbiter
interface client_req_if;
   import l2_pkg::*;

   logic   valid;   // Queue not empty
   l2_op_t op;
   paddr_t addr;
   line_t  data;
   logic   pop;     // Head granted this cycle

   modport queue (output valid, op, addr, data, input pop);
   modport arb (input valid, op, addr, data, output pop);
endinterface

// Granted request into the shared L2
interface l2_req_if;
   import l2_pkg::*;

   logic    valid;
   client_t client;
   l2_op_t  op;
   paddr_t  addr;
   line_t   data;
   logic    busy;

   modport arb (output valid, client, op, addr, data, input busy);
   modport cache (input valid, client, op, addr, data, output busy);
endinterface

// File: hw/client_queue.sv
`timescale 1ns/100ps
`include "l2_params.svh"

module client_queue
(
   input  logic            clk,
   input  logic            reset,
   input  logic            req_valid,
   input  l2_pkg::l2_op_t  req_op,
   input  l2_pkg::paddr_t  req_addr,
   input  l2_pkg::line_t   req_data,
   output logic            credit,
   client_req_if.queue     q
);
   import l2_pkg::*;

   localparam int DEPTH = `L2_CREDITS;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   l2_op_t           op_mem   [DEPTH];
   paddr_t           addr_mem [DEPTH];
   line_t            data_mem [DEPTH];
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W:0]   count;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
         credit <= 1'b0;
      end
      else
      begin
         credit <= q.pop;   // Credit goes back the cycle after the pop
         if (req_valid)
            wr_ptr <= next_ptr(wr_ptr);
         if (q.pop)
            rd_ptr <= next_ptr(rd_ptr);
         case ({req_valid, q.pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // No overflow check, the sender's credits bound the occupancy
   always_ff @(posedge clk)
   begin
      if (req_valid)
      begin
         op_mem[wr_ptr]   <= req_op;
         addr_mem[wr_ptr] <= req_addr;
         data_mem[wr_ptr] <= req_data;
      end
   end

   assign q.valid = (count != '0);
   assign q.op    = op_mem[rd_ptr];
   assign q.addr  = addr_mem[rd_ptr];
   assign q.data  = data_mem[rd_ptr];

endmodule

// File: hw/l2_arbiter.sv
`timescale 1ns/100ps

module l2_arbiter
(
   input  logic      clk,
   input  logic      reset,
   input  logic      in_flush_mode,
   client_req_if.arb l1i,
   client_req_if.arb l1d,
   client_req_if.arb mmu,
   l2_req_if.arb     l2
);
   import l2_pkg::*;

   client_t    last_grant;
   client_t    pick;
   logic [2:0] pending;
   logic       any;
   logic       grant;

   assign pending = {mmu.valid, l1d.valid, l1i.valid};   // Indexed by client_t

   // First non-empty queue after the last one served
   always_comb
   begin
      pick = last_grant;
      any  = 1'b0;
      for (int i = 1; i <= 3; i++)
      begin
         if (!any && pending[(int'(last_grant) + i) % 3])
         begin
            pick = client_t'((int'(last_grant) + i) % 3);
            any  = 1'b1;
         end
      end
   end

   assign grant = any && !l2.busy && !in_flush_mode;

   always_ff @(posedge clk)
   begin
      if (reset)
         last_grant <= CLIENT_MMU;   // L1I goes first
      else if (grant)
         last_grant <= pick;
   end

   always_comb
   begin
      case (pick)
         CLIENT_L1D:
         begin
            l2.op   = l1d.op;
            l2.addr = l1d.addr;
            l2.data = l1d.data;
         end
         CLIENT_MMU:
         begin
            l2.op   = mmu.op;
            l2.addr = mmu.addr;
            l2.data = mmu.data;
         end
         default:
         begin
            l2.op   = l1i.op;
            l2.addr = l1i.addr;
            l2.data = l1i.data;
         end
      endcase
   end

   assign l2.valid  = grant;
   assign l2.client = pick;

   assign l1i.pop = grant && (pick == CLIENT_L1I);
   assign l1d.pop = grant && (pick == CLIENT_L1D);
   assign mmu.pop = grant && (pick == CLIENT_MMU);

endmodule

// File: hw/flush_sequencer.sv
`timescale 1ns/100ps

module flush_sequencer
(
   input  logic clk,
   input  logic reset,
   input  logic flush_req_l1i,
   input  logic flush_req_l1d,
   input  logic l1i_flush_complete,
   input  logic l1d_flush_complete,
   input  logic l2_flush_done,
   output logic in_flush_mode,
   output logic l2_flush_start
);
   import l2_pkg::*;

   flush_state_t state;
   flush_state_t n_state;
   logic         n_flush;
   logic         n_flush_l2;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state          <= FLUSH_IDLE;
         in_flush_mode  <= 1'b0;
         l2_flush_start <= 1'b0;
      end
      else
      begin
         state          <= n_state;
         in_flush_mode  <= n_flush;
         l2_flush_start <= n_flush_l2;   // One cycle pulse
      end
   end

   // An L1 that was not asked to flush counts as already finished
   always_comb
   begin
      n_state    = state;
      n_flush    = in_flush_mode;
      n_flush_l2 = 1'b0;
      case (state)
         FLUSH_IDLE:
         begin
            if (flush_req_l1i || flush_req_l1d)
               n_flush = 1'b1;
            if (flush_req_l1i && flush_req_l1d)
               n_state = WAIT_FOR_L1D_L1I;
            else if (flush_req_l1i)
               n_state = GOT_L1D;
            else if (flush_req_l1d)
               n_state = GOT_L1I;
         end
         WAIT_FOR_L1D_L1I:
         begin
            if (l1d_flush_complete && l1i_flush_complete)
            begin
               n_state    = FLUSH_L2;
               n_flush_l2 = 1'b1;
            end
            else if (l1d_flush_complete)
               n_state = GOT_L1D;
            else if (l1i_flush_complete)
               n_state = GOT_L1I;
         end
         GOT_L1D:
         begin
            if (l1i_flush_complete)
            begin
               n_state    = FLUSH_L2;
               n_flush_l2 = 1'b1;
            end
         end
         GOT_L1I:
         begin
            if (l1d_flush_complete)
            begin
               n_state    = FLUSH_L2;
               n_flush_l2 = 1'b1;
            end
         end
         FLUSH_L2:
         begin
            if (l2_flush_done)
            begin
               n_state = FLUSH_IDLE;
               n_flush = 1'b0;
            end
         end
         default:
            n_state = FLUSH_IDLE;
      endcase
   end

endmodule

// File: hw/l2_cache.sv
`timescale 1ns/100ps
`include "l2_params.svh"

module l2_cache
(
   input  logic            clk,
   input  logic            reset,
   l2_req_if.cache         req,
   input  logic            flush_start,
   output logic            flush_done,
   output logic            l1i_rsp_valid,
   output logic            l1d_rsp_valid,
   output logic            mmu_rsp_valid,
   output l2_pkg::line_t   rsp_line,
   output l2_pkg::word_t   mmu_rsp_word,
   output logic            mem_req_valid,
   output l2_pkg::paddr_t  mem_req_addr,
   output l2_pkg::l2_op_t  mem_req_op,
   output l2_pkg::line_t   mem_req_data,
   input  logic            mem_rsp_valid,
   input  l2_pkg::line_t   mem_rsp_line,
   output l2_pkg::count_t  cache_accesses,
   output l2_pkg::count_t  cache_hits
);
   import l2_pkg::*;

   localparam int LINES = 1 << `L2_LG_LINES;

   l2_state_t        state;
   l2_tag_t          tag_arr  [LINES];
   line_t            data_arr [LINES];
   logic [LINES-1:0] valid_bits;
   logic [LINES-1:0] dirty_bits;

   client_t r_client;
   l2_op_t  r_op;
   paddr_t  r_addr;
   line_t   r_data;
   line_t   r_line;

   l2_idx_t idx;
   l2_tag_t tag;
   l2_idx_t fidx;     // Flush walk position
   l2_idx_t wb_idx;
   line_t   fill_line;
   logic    hit;
   logic    victim_dirty;
   logic    flush_dirty;
   logic    flush_pend;
   logic    mem_issued;

   assign idx          = r_addr[`L2_OFF_W +: `L2_LG_LINES];
   assign tag          = r_addr[`L2_ADDR_W-1 -: `L2_TAG_W];
   assign hit          = valid_bits[idx] && (tag_arr[idx] == tag);
   assign victim_dirty = valid_bits[idx] && dirty_bits[idx];
   assign flush_dirty  = valid_bits[fidx] && dirty_bits[fidx];
   assign fill_line    = (r_op == OP_WRITE) ? r_data : mem_rsp_line;   // Full line store

   // One memory operation at a time, request held until issued once
   assign wb_idx        = (state == FLUSH_WALK) ? fidx : idx;
   assign mem_req_valid = !mem_issued && ((state == WRITEBACK) || (state == REFILL) ||
                                          ((state == FLUSH_WALK) && flush_dirty));
   assign mem_req_op    = (state == REFILL) ? OP_READ : OP_WRITE;
   assign mem_req_addr  = (state == REFILL) ? {tag, idx, {`L2_OFF_W{1'b0}}}
                                            : {tag_arr[wb_idx], wb_idx, {`L2_OFF_W{1'b0}}};
   assign mem_req_data  = data_arr[wb_idx];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state          <= IDLE;
         valid_bits     <= '0;
         dirty_bits     <= '0;
         mem_issued     <= 1'b0;
         flush_pend     <= 1'b0;
         flush_done     <= 1'b0;
         fidx           <= '0;
         cache_accesses <= '0;
         cache_hits     <= '0;
      end
      else
      begin
         flush_done <= 1'b0;
         if (flush_start)
            flush_pend <= 1'b1;   // Start may arrive while a request is in progress
         if (mem_req_valid)
            mem_issued <= 1'b1;
         if (mem_rsp_valid)
            mem_issued <= 1'b0;
         case (state)
            IDLE:
            begin
               if (req.valid)
                  state <= LOOKUP;
               else if (flush_pend)
               begin
                  state      <= FLUSH_WALK;
                  flush_pend <= 1'b0;
                  fidx       <= '0;
               end
            end
            LOOKUP:
            begin
               cache_accesses <= cache_accesses + 1'b1;
               if (hit)
               begin
                  cache_hits <= cache_hits + 1'b1;
                  if (r_op == OP_WRITE)
                     dirty_bits[idx] <= 1'b1;
                  state <= RESPOND;
               end
               else if (victim_dirty)
                  state <= WRITEBACK;
               else
                  state <= REFILL;
            end
            WRITEBACK:
            begin
               if (mem_rsp_valid)
                  state <= REFILL;
            end
            REFILL:
            begin
               if (mem_rsp_valid)
               begin
                  valid_bits[idx] <= 1'b1;
                  dirty_bits[idx] <= (r_op == OP_WRITE);
                  state           <= RESPOND;
               end
            end
            RESPOND: state <= IDLE;
            FLUSH_WALK:
            begin
               if (flush_dirty)
               begin
                  if (mem_rsp_valid)
                     dirty_bits[fidx] <= 1'b0;
               end
               else if (fidx == '1)
               begin
                  valid_bits <= '0;
                  flush_done <= 1'b1;
                  state      <= IDLE;
               end
               else
                  fidx <= fidx + 1'b1;
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if ((state == IDLE) && req.valid)
      begin
         r_client <= req.client;
         r_op     <= req.op;
         r_addr   <= req.addr;
         r_data   <= req.data;
      end
      if ((state == LOOKUP) && hit)
      begin
         if (r_op == OP_WRITE)
            data_arr[idx] <= r_data;
         r_line <= (r_op == OP_WRITE) ? r_data : data_arr[idx];
      end
      if ((state == REFILL) && mem_rsp_valid)
      begin
         tag_arr[idx]  <= tag;
         data_arr[idx] <= fill_line;
         r_line        <= fill_line;
      end
   end

   assign req.busy = (state != IDLE);

   assign l1i_rsp_valid = (state == RESPOND) && (r_client == CLIENT_L1I);
   assign l1d_rsp_valid = (state == RESPOND) && (r_client == CLIENT_L1D);
   assign mmu_rsp_valid = (state == RESPOND) && (r_client == CLIENT_MMU);
   assign rsp_line      = r_line;
   assign mmu_rsp_word  = r_addr[3] ? r_line[`L2_LINE_W-1 -: `L2_WORD_W]
                                    : r_line[`L2_WORD_W-1:0];

endmodule

// File: hw/mem_subsys_top.sv
`timescale 1ns/100ps

module mem_subsys_top
(
   input  logic            clk,
   input  logic            reset,

   input  logic            l1i_req_valid,
   input  l2_pkg::paddr_t  l1i_req_addr,
   output logic            l1i_credit,
   output logic            l1i_rsp_valid,

   input  logic            l1d_req_valid,
   input  l2_pkg::l2_op_t  l1d_req_op,
   input  l2_pkg::paddr_t  l1d_req_addr,
   input  l2_pkg::line_t   l1d_req_data,
   output logic            l1d_credit,
   output logic            l1d_rsp_valid,

   input  logic            mmu_req_valid,
   input  l2_pkg::paddr_t  mmu_req_addr,
   output logic            mmu_credit,
   output logic            mmu_rsp_valid,

   output l2_pkg::line_t   rsp_line,       // Shared by both L1 ports
   output l2_pkg::word_t   mmu_rsp_word,

   output logic            mem_req_valid,
   output l2_pkg::paddr_t  mem_req_addr,
   output l2_pkg::l2_op_t  mem_req_op,
   output l2_pkg::line_t   mem_req_data,
   input  logic            mem_rsp_valid,
   input  l2_pkg::line_t   mem_rsp_line,

   input  logic            flush_req_l1i,
   input  logic            flush_req_l1d,
   input  logic            l1i_flush_complete,
   input  logic            l1d_flush_complete,
   output logic            in_flush_mode,

   output l2_pkg::count_t  l2_cache_accesses,
   output l2_pkg::count_t  l2_cache_hits
);

   logic l2_flush_start;
   logic l2_flush_done;

   client_req_if l1i_q ();
   client_req_if l1d_q ();
   client_req_if mmu_q ();
   l2_req_if     l2_req ();

   client_queue l1i_queue_i (
      .clk       (clk),
      .reset     (reset),
      .req_valid (l1i_req_valid),
      .req_op    (l2_pkg::OP_READ),
      .req_addr  (l1i_req_addr),
      .req_data  ('0),
      .credit    (l1i_credit),
      .q         (l1i_q)
   );

   client_queue l1d_queue_i (
      .clk       (clk),
      .reset     (reset),
      .req_valid (l1d_req_valid),
      .req_op    (l1d_req_op),
      .req_addr  (l1d_req_addr),
      .req_data  (l1d_req_data),
      .credit    (l1d_credit),
      .q         (l1d_q)
   );

   client_queue mmu_queue_i (
      .clk       (clk),
      .reset     (reset),
      .req_valid (mmu_req_valid),
      .req_op    (l2_pkg::OP_READ),
      .req_addr  (mmu_req_addr),
      .req_data  ('0),
      .credit    (mmu_credit),
      .q         (mmu_q)
   );

   l2_arbiter l2_arbiter_i (
      .clk           (clk),
      .reset         (reset),
      .in_flush_mode (in_flush_mode),
      .l1i           (l1i_q),
      .l1d           (l1d_q),
      .mmu           (mmu_q),
      .l2            (l2_req)
   );

   flush_sequencer flush_sequencer_i (
      .clk                (clk),
      .reset              (reset),
      .flush_req_l1i      (flush_req_l1i),
      .flush_req_l1d      (flush_req_l1d),
      .l1i_flush_complete (l1i_flush_complete),
      .l1d_flush_complete (l1d_flush_complete),
      .l2_flush_done      (l2_flush_done),
      .in_flush_mode      (in_flush_mode),
      .l2_flush_start     (l2_flush_start)
   );

   l2_cache l2_cache_i (
      .clk            (clk),
      .reset          (reset),
      .req            (l2_req),
      .flush_start    (l2_flush_start),
      .flush_done     (l2_flush_done),
      .l1i_rsp_valid  (l1i_rsp_valid),
      .l1d_rsp_valid  (l1d_rsp_valid),
      .mmu_rsp_valid  (mmu_rsp_valid),
      .rsp_line       (rsp_line),
      .mmu_rsp_word   (mmu_rsp_word),
      .mem_req_valid  (mem_req_valid),
      .mem_req_addr   (mem_req_addr),
      .mem_req_op     (mem_req_op),
      .mem_req_data   (mem_req_data),
      .mem_rsp_valid  (mem_rsp_valid),
      .mem_rsp_line   (mem_rsp_line),
      .cache_accesses (l2_cache_accesses),
      .cache_hits     (l2_cache_hits)
   );

endmodule

// File: tb/mem_subsys_props.sv
`timescale 1ns/100ps
`include "l2_params.svh"

module mem_subsys_props
(
   input logic clk,
   input logic reset,
   input logic l1i_req_valid,
   input logic l1d_req_valid,
   input logic mmu_req_valid,
   input logic l1i_credit,
   input logic l1d_credit,
   input logic mmu_credit,
   input logic grant,
   input logic in_flush_mode,
   input logic l1i_rsp_valid,
   input logic l1d_rsp_valid,
   input logic mmu_rsp_valid
);
   int out_l1i;   // Requests sent and not yet credited back
   int out_l1d;
   int out_mmu;
   int assert_fails = 0;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         out_l1i <= 0;
         out_l1d <= 0;
         out_mmu <= 0;
      end
      else
      begin
         out_l1i <= out_l1i + int'(l1i_req_valid) - int'(l1i_credit);
         out_l1d <= out_l1d + int'(l1d_req_valid) - int'(l1d_credit);
         out_mmu <= out_mmu + int'(mmu_req_valid) - int'(mmu_credit);
      end
   end

   // A credit may only come back for a request that was sent
   a_l1i_credits: assert property (@(posedge clk) disable iff (reset)
      out_l1i >= 0 && out_l1i <= `L2_CREDITS)
   else
   begin
      $error("l1i outstanding requests outside 0 to the credit count");
      assert_fails++;
   end
   a_l1d_credits: assert property (@(posedge clk) disable iff (reset)
      out_l1d >= 0 && out_l1d <= `L2_CREDITS)
   else
   begin
      $error("l1d outstanding requests outside 0 to the credit count");
      assert_fails++;
   end
   a_mmu_credits: assert property (@(posedge clk) disable iff (reset)
      out_mmu >= 0 && out_mmu <= `L2_CREDITS)
   else
   begin
      $error("mmu outstanding requests outside 0 to the credit count");
      assert_fails++;
   end

   a_no_flush_grant: assert property (@(posedge clk) disable iff (reset)
      in_flush_mode |-> !grant)
   else
   begin
      $error("L2 request granted during a flush");
      assert_fails++;
   end

   a_one_rsp: assert property (@(posedge clk) disable iff (reset)
      $onehot0({l1i_rsp_valid, l1d_rsp_valid, mmu_rsp_valid}))
   else
   begin
      $error("more than one response valid in a cycle");
      assert_fails++;
   end

endmodule

bind mem_subsys_top mem_subsys_props props_i (
   .clk           (clk),
   .reset         (reset),
   .l1i_req_valid (l1i_req_valid),
   .l1d_req_valid (l1d_req_valid),
   .mmu_req_valid (mmu_req_valid),
   .l1i_credit    (l1i_credit),
   .l1d_credit    (l1d_credit),
   .mmu_credit    (mmu_credit),
   .grant         (l2_req.valid),
   .in_flush_mode (in_flush_mode),
   .l1i_rsp_valid (l1i_rsp_valid),
   .l1d_rsp_valid (l1d_rsp_valid),
   .mmu_rsp_valid (mmu_rsp_valid)
);

// File: tb/mem_subsys_checker.sv
`timescale 1ns/100ps

module mem_subsys_checker
(
   input logic            clk,
   input logic            reset,
   input logic            l1i_req_valid,
   input logic            l1d_req_valid,
   input logic            mmu_req_valid,
   input logic            l1i_credit,
   input logic            l1d_credit,
   input logic            mmu_credit,
   input logic            l1i_rsp_valid,
   input logic            l1d_rsp_valid,
   input logic            mmu_rsp_valid,
   input l2_pkg::line_t   rsp_line,
   input l2_pkg::word_t   mmu_rsp_word,
   input logic            mem_req_valid,
   input l2_pkg::l2_op_t  mem_req_op,
   input l2_pkg::paddr_t  mem_req_addr,
   input l2_pkg::line_t   mem_req_data,
   input logic            in_flush_mode,
   input l2_pkg::count_t  l2_cache_accesses,
   input l2_pkg::count_t  l2_cache_hits
);
   import l2_pkg::*;

   line_t  exp_l1i[$];
   line_t  exp_l1d[$];
   line_t  exp_mmu[$];
   paddr_t wr_addr_q[$];
   line_t  wr_data_q[$];
   int     out_cnt[3];
   int     err_count = 0;
   int     test_errs = 0;
   int     tests = 0;
   int     failed = 0;
   logic   was_flushing = 1'b0;

   task automatic compare(input string name, input line_t exp, input line_t got);
      if (exp !== got)
      begin
         $display("ERR %0t %s exp %h got %h", $time, name, exp, got);
         err_count++;
         test_errs++;
      end
   endtask

   task automatic fail_msg(input string msg);
      $display("%0t: %s", $time, msg);
      err_count++;
      test_errs++;
   endtask

   task automatic expect_rsp(input int c, input line_t v);
      if (c == 0)
         exp_l1i.push_back(v);
      else if (c == 1)
         exp_l1d.push_back(v);
      else
         exp_mmu.push_back(v);
   endtask

   task automatic expect_write(input paddr_t a, input line_t d);
      wr_addr_q.push_back(a);
      wr_data_q.push_back(d);
   endtask

   function automatic bit idle();
      return exp_l1i.size() == 0 && exp_l1d.size() == 0 && exp_mmu.size() == 0 &&
             out_cnt[0] == 0 && out_cnt[1] == 0 && out_cnt[2] == 0;
   endfunction

   task automatic check_counters(input count_t acc, input count_t hits);
      compare("l2_cache_accesses", line_t'(acc), line_t'(l2_cache_accesses));
      compare("l2_cache_hits", line_t'(hits), line_t'(l2_cache_hits));
   endtask

   task automatic check_writes_done();
      if (wr_addr_q.size() != 0)
         fail_msg($sformatf("%0d expected memory writes never happened", wr_addr_q.size()));
      wr_addr_q.delete();
      wr_data_q.delete();
   endtask

   task automatic end_test(input int t);
      check_writes_done();
      tests++;
      if (test_errs == 0)
         $display("test %0d: pass", t);
      else
      begin
         $display("test %0d: FAIL with %0d errors", t, test_errs);
         failed++;
      end
      test_errs = 0;
   endtask

   task automatic report();
      $display("tests %0d, failed %0d, errors %0d", tests, failed, err_count);
   endtask

   // Sampled mid-cycle, away from the edges where inputs and outputs change
   always @(negedge clk)
   begin
      if (!reset)
      begin
         out_cnt[0] += int'(l1i_req_valid) - int'(l1i_credit);
         out_cnt[1] += int'(l1d_req_valid) - int'(l1d_credit);
         out_cnt[2] += int'(mmu_req_valid) - int'(mmu_credit);
         if (l1i_rsp_valid)
         begin
            if (exp_l1i.size() == 0)
               fail_msg("l1i got a response it did not ask for");
            else
               compare("l1i rsp_line", exp_l1i.pop_front(), rsp_line);
         end
         if (l1d_rsp_valid)
         begin
            if (exp_l1d.size() == 0)
               fail_msg("l1d got a response it did not ask for");
            else
               compare("l1d rsp_line", exp_l1d.pop_front(), rsp_line);
         end
         if (mmu_rsp_valid)
         begin
            if (exp_mmu.size() == 0)
               fail_msg("mmu got a response it did not ask for");
            else
               compare("mmu_rsp_word", exp_mmu.pop_front(), line_t'(mmu_rsp_word));
         end
         if (mem_req_valid && mem_req_op == OP_WRITE)
         begin
            if (wr_addr_q.size() == 0)
               fail_msg($sformatf("unexpected memory write to %h", mem_req_addr));
            else
            begin
               compare("mem_req_addr", line_t'(wr_addr_q.pop_front()), line_t'(mem_req_addr));
               compare("mem_req_data", wr_data_q.pop_front(), mem_req_data);
            end
         end
         // Every dirty line must be written back before flush mode ends
         if (was_flushing && !in_flush_mode)
            check_writes_done();
         was_flushing = in_flush_mode;
      end
   end

endmodule

// File: tb/mem_subsys_tb.sv
`timescale 1ns/100ps
`include "l2_params.svh"

module mem_subsys_tb;
   import l2_pkg::*;

   logic   clk;
   logic   reset;
   logic   l1i_req_valid, l1d_req_valid, mmu_req_valid;
   l2_op_t l1d_req_op;
   paddr_t l1i_req_addr, l1d_req_addr, mmu_req_addr;
   line_t  l1d_req_data;
   logic   l1i_credit, l1d_credit, mmu_credit;
   logic   l1i_rsp_valid, l1d_rsp_valid, mmu_rsp_valid;
   line_t  rsp_line;
   word_t  mmu_rsp_word;
   logic   mem_req_valid;
   paddr_t mem_req_addr;
   l2_op_t mem_req_op;
   line_t  mem_req_data;
   logic   mem_rsp_valid;
   line_t  mem_rsp_line;
   logic   flush_req_l1i, flush_req_l1d;
   logic   l1i_flush_complete, l1d_flush_complete;
   logic   in_flush_mode;
   count_t l2_cache_accesses, l2_cache_hits;

   int     st_test[$];
   byte    st_act[$];
   int     st_client[$];
   int     st_op[$];
   paddr_t st_addr[$];
   line_t  st_data[$];
   line_t  st_exp[$];
   int     n_lines = 0;
   int     credits[3];
   line_t  mem_model[paddr_t];

   mem_subsys_top mem_subsys_top_i (.*);

   mem_subsys_checker checker_i (.*);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Memory rule for lines never written: word k of line A holds A ^ k
   function automatic line_t default_line(input paddr_t a);
      line_t l;
      for (int k = 0; k < 4; k++)
         l[32*k +: 32] = a ^ k;
      return l;
   endfunction

   initial
   begin
      paddr_t a;
      mem_rsp_valid = 1'b0;
      mem_rsp_line  = '0;
      forever
      begin
         @(negedge clk);
         if (mem_req_valid)
         begin
            a = mem_req_addr;
            if (mem_req_op == OP_WRITE)
               mem_model[a] = mem_req_data;
            repeat (`L2_MEM_LAT) @(posedge clk);
            #2;
            mem_rsp_valid = 1'b1;
            mem_rsp_line  = mem_model.exists(a) ? mem_model[a] : default_line(a);
            @(posedge clk);
            #2 mem_rsp_valid = 1'b0;
         end
      end
   end

   always @(negedge clk)
   begin
      if (l1i_credit)
         credits[0]++;
      if (l1d_credit)
         credits[1]++;
      if (mmu_credit)
         credits[2]++;
   end

   initial
   begin
      wait (n_lines > 0);
      #(n_lines * 60 * 20);
      $display("Timeout: the requests did not complete in time");
      $display("Finished with errors");
      $finish;
   end

   task automatic read_stimulus();
      int     fd;
      int     n;
      string  line;
      int     t, c, op;
      byte    act;
      paddr_t a;
      line_t  d, e;
      fd = $fopen("tb/mem_subsys_stimulus.txt", "r");
      if (fd == 0)
         checker_i.fail_msg("cannot open the stimulus file tb/mem_subsys_stimulus.txt");
      else
      begin
         while (!$feof(fd))
         begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#")
            begin
               n = $sscanf(line, "%d %c %d %d %h %h %h", t, act, c, op, a, d, e);
               if (n == 7 && act == "K")
                  n = $sscanf(line, "%d %c %d %d %h %d %d", t, act, c, op, a, d, e);   // Counts are decimal
               if (n == 7)
               begin
                  st_test.push_back(t);
                  st_act.push_back(act);
                  st_client.push_back(c);
                  st_op.push_back(op);
                  st_addr.push_back(a);
                  st_data.push_back(d);
                  st_exp.push_back(e);
               end
            end
         end
         $fclose(fd);
      end
      n_lines = st_test.size();
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      #2;
      l1i_req_valid = 1'b0;
      l1d_req_valid = 1'b0;
      mmu_req_valid = 1'b0;
   endtask

   task automatic send_req(input int c, input l2_op_t op, input paddr_t a, input line_t d);
      idle_cycle();
      while (credits[c] == 0)
         idle_cycle();
      credits[c]--;
      case (c)
         0:
         begin
            l1i_req_valid = 1'b1;
            l1i_req_addr  = a;
         end
         1:
         begin
            l1d_req_valid = 1'b1;
            l1d_req_op    = op;
            l1d_req_addr  = a;
            l1d_req_data  = d;
         end
         default:
         begin
            mmu_req_valid = 1'b1;
            mmu_req_addr  = a;
         end
      endcase
   endtask

   task automatic drain();
      idle_cycle();
      while (!checker_i.idle() || in_flush_mode)
         idle_cycle();
   endtask

   // Order 0 gives L1I complete first, 1 gives L1D first, 2 gives both together
   // Returns while the L2 walk still runs, so later requests wait in their queues
   task automatic run_flush(input int order);
      drain();
      flush_req_l1i = 1'b1;
      flush_req_l1d = 1'b1;
      idle_cycle();
      flush_req_l1i = 1'b0;
      flush_req_l1d = 1'b0;
      repeat (3) idle_cycle();
      l1i_flush_complete = (order != 1);
      l1d_flush_complete = (order != 0);
      idle_cycle();
      l1i_flush_complete = (order == 1);
      l1d_flush_complete = (order == 0);
      idle_cycle();
      l1i_flush_complete = 1'b0;
      l1d_flush_complete = 1'b0;
   endtask

   initial
   begin
      reset = 1'b1;
      l1i_req_valid = 1'b0;
      l1d_req_valid = 1'b0;
      mmu_req_valid = 1'b0;
      l1d_req_op    = OP_READ;
      l1i_req_addr  = '0;
      l1d_req_addr  = '0;
      mmu_req_addr  = '0;
      l1d_req_data  = '0;
      flush_req_l1i = 1'b0;
      flush_req_l1d = 1'b0;
      l1i_flush_complete = 1'b0;
      l1d_flush_complete = 1'b0;
      for (int i = 0; i < 3; i++)
         credits[i] = `L2_CREDITS;
      read_stimulus();
      repeat (10) @(posedge clk);
      #2 reset = 1'b0;
      for (int i = 0; i < n_lines; i++)
      begin
         case (st_act[i])
            "R":
            begin
               send_req(st_client[i], l2_op_t'(st_op[i]), st_addr[i], st_data[i]);
               checker_i.expect_rsp(st_client[i], st_exp[i]);
            end
            "X": checker_i.expect_write(st_addr[i], st_data[i]);
            "F": run_flush(st_client[i]);
            "K":
            begin
               drain();
               checker_i.check_counters(count_t'(st_data[i]), count_t'(st_exp[i]));
            end
            "E":
            begin
               drain();
               checker_i.end_test(st_test[i]);
            end
            default: checker_i.fail_msg($sformatf("unknown stimulus action on line %0d", i));
         endcase
      end
      drain();
      checker_i.report();
      if (checker_i.err_count == 0 && mem_subsys_top_i.props_i.assert_fails == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

// File: tb/mem_subsys_stimulus.txt
# test action client op addr data expected (hex); action R request, X memory write expected,
# F flush with client as complete order, K counters (data accesses, expected hits), E end
1 R 0 0 00001000 0 00001003000010020000100100001000
1 R 0 0 00001000 0 00001003000010020000100100001000
1 K 0 0 0 2 1
1 E 0 0 0 0 0
2 R 1 1 00002010 0123456789abcdeffedcba9876543210 0123456789abcdeffedcba9876543210
2 R 0 0 00002010 0 0123456789abcdeffedcba9876543210
2 K 0 0 0 4 2
2 E 0 0 0 0 0
3 R 2 0 00003028 0 0000302300003022
3 R 2 0 00003020 0 0000302100003020
3 K 0 0 0 6 3
3 E 0 0 0 0 0
4 R 1 1 00004030 11112222333344445555666677778888 11112222333344445555666677778888
4 X 0 0 00004030 11112222333344445555666677778888 0
4 R 0 0 00005030 0 00005033000050320000503100005030
4 R 0 0 00004030 0 11112222333344445555666677778888
4 K 0 0 0 9 3
4 E 0 0 0 0 0
5 R 1 1 00006040 deadbeef00c0ffee12345678cafef00d deadbeef00c0ffee12345678cafef00d
5 X 0 0 00002010 0123456789abcdeffedcba9876543210 0
5 X 0 0 00006040 deadbeef00c0ffee12345678cafef00d 0
5 F 1 0 0 0 0
5 R 0 0 00001000 0 00001003000010020000100100001000
5 K 0 0 0 11 3
5 E 0 0 0 0 0
6 R 0 0 00007050 0 00007053000070520000705100007050
6 R 1 0 00008060 0 00008063000080620000806100008060
6 R 2 0 00009070 0 0000907100009070
6 R 0 0 00007050 0 00007053000070520000705100007050
6 R 1 0 0000a080 0 0000a0830000a0820000a0810000a080
6 R 2 0 00009078 0 0000907300009072
6 E 0 0 0 0 0

// File: src.f
+incdir+include
hw/l2_pkg.sv
hw/l2_ifs.sv
hw/client_queue.sv
hw/l2_arbiter.sv
hw/flush_sequencer.sv
hw/l2_cache.sv
hw/mem_subsys_top.sv
tb/mem_subsys_props.sv
tb/mem_subsys_checker.sv
tb/mem_subsys_tb.sv

// File: Bender.yml
package:
  name: mem_subsys

sources:
  - include_dirs:
      - include
    files:
      - hw/l2_pkg.sv
      - hw/l2_ifs.sv
      - hw/client_queue.sv
      - hw/l2_arbiter.sv
      - hw/flush_sequencer.sv
      - hw/l2_cache.sv
      - hw/mem_subsys_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/mem_subsys_props.sv
      - tb/mem_subsys_checker.sv
      - tb/mem_subsys_tb.sv
